//--- Makefile
# Verilator build and run of the RSA key generator testbench
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps -Wno-fatal
TOP      := rsa_keygen_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+include
verilog/rsa_key_pkg.sv
verilog/keygen_ctrl_pkg.sv
verilog/ext_euclid_engine.sv
verilog/prime_set_loader.sv
verilog/exponent_unit.sv
verilog/pair_inverse_unit.sv
verilog/crt_combiner.sv
verilog/rsa_keygen_top.sv
sim/rsa_keygen_checker.sv
sim/rsa_keygen_tb.sv

//--- include/rsa_keygen_defs.svh
// key generator sizing macros
// key width, public exponent, prime count, output credit depth
`ifndef RSA_KEYGEN_DEFS_SVH
`define RSA_KEYGEN_DEFS_SVH

// width of every prime and key word
`define KEY_WIDTH   32

// fixed public exponent (F4)
`define PUB_EXP     65537

// primes per key set
`define NUM_PRIMES  4

// most output credits the combiner can bank
`define KEY_CREDITS 4

`endif

//--- sim/rsa_keygen_checker.sv
// port watcher for reset quiet, credit rules, beat order and key values
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module rsa_keygen_checker import rsa_key_pkg::*; (
	input  wire             aclk,
	input  wire             aresetn,
	input  wire             prime_valid,
	input  wire             prime_credit,
	input  wire             key_credit,
	input  wire             key_valid,
	input  wire prime_idx_t key_index,
	input  wire key_word_t  key_d,
	input  wire key_word_t  key_c,
	input  wire prime_set_t model_d,   // taken along with prime_valid
	input  wire prime_set_t model_c,
	output int              tests_run,
	output int              tests_failed,
	output int              error_count
);

	prime_set_t exp_d_q, exp_c_q;   // expected for the set in flight
	int         n_run, n_failed, n_err;
	int         owed;               // output credits not yet spent
	int         beats;              // beats of the current set
	int         set_num;
	int         rst_cycles;
	bit         in_flight, src_credit, first_credit;
	bit         set_bad, rst_bad;
	string      tname;

	assign tests_run    = n_run;
	assign tests_failed = n_failed;
	assign error_count  = n_err;

	initial begin
		n_run        = 0;
		n_failed     = 0;
		n_err        = 0;
		owed         = 0;
		beats        = 0;
		set_num      = 0;
		rst_cycles   = 0;
		in_flight    = 1'b0;
		src_credit   = 1'b0;
		first_credit = 1'b0;
		set_bad      = 1'b0;
		rst_bad      = 1'b0;
		tname        = "reset_idle";
	end

	task automatic flag_error(input string msg);
		$display("%s: %s", tname, msg);
		n_err++;
		if (in_flight) set_bad = 1'b1;
		if (!first_credit) rst_bad = 1'b1;
	endtask

	task automatic compare_word(input string what, input key_word_t expected,
		input key_word_t actual);
		if (expected !== actual) begin
			$display("Mismatch %s %s: expected %0d actual %0d", tname, what, expected, actual);
			n_err++;
			set_bad = 1'b1;
		end
	endtask

	always @(posedge aclk) begin
		if (!aresetn) begin
			rst_cycles++;
			// first edge still shows power-up state
			if (rst_cycles > 1 && (key_valid || prime_credit)) begin
				flag_error("key_valid or prime_credit high during reset");
			end
		end else begin
			// ------------------------------
			// input side
			// ------------------------------
			if (prime_credit) begin
				if (!first_credit) begin
					first_credit = 1'b1; // closes the reset test
					n_run++;
					if (rst_bad) n_failed++;
					$display("test reset_idle: %s", rst_bad ? "FAIL" : "pass");
				end else if (src_credit || in_flight) begin
					flag_error("extra prime_credit before the fourth beat of the open set");
				end
				src_credit = 1'b1;
			end
			if (prime_valid) begin
				src_credit = 1'b0;
				in_flight  = 1'b1;
				beats      = 0;
				set_bad    = 1'b0;
				exp_d_q    = model_d;
				exp_c_q    = model_c;
				tname      = $sformatf("set_%02d", set_num);
			end
			// ------------------------------
			// output side
			// ------------------------------
			if (key_valid) begin
				if (owed == 0) flag_error("key_valid with no unspent output credit");
				if (!in_flight) begin
					flag_error("key_valid with no prime set in flight");
				end else begin
					compare_word("key_index", key_word_t'(beats), key_word_t'(key_index));
					compare_word($sformatf("key_d[%0d]", beats), exp_d_q[beats], key_d);
					compare_word($sformatf("key_c[%0d]", beats), exp_c_q[beats], key_c);
					beats++;
					if (beats == `NUM_PRIMES) begin // set complete
						in_flight = 1'b0;
						n_run++;
						if (set_bad) n_failed++;
						$display("test %s: %s", tname, set_bad ? "FAIL" : "pass");
						set_num++;
					end
				end
			end
			if (key_credit) owed++;
			if (key_valid && owed > 0) owed--;
		end
	end

endmodule

`default_nettype wire

//--- sim/rsa_keygen_tb.sv
// testbench top: clock, reset, random prime sets, output credit traffic
// reference model for private exponents and crt coefficients
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module rsa_keygen_tb import rsa_key_pkg::*; ();

	localparam int          NUM_SETS       = 20;
	localparam int          RESET_CYCLES   = 8;
	localparam int          CREDIT_TIMEOUT = 5000;       // cycles per wait
	localparam int          PRIME_TOP      = 65521;      // largest 16-bit prime
	localparam logic [31:0] RAND_SEED      = 32'h1f20ac51;

	logic       aclk;
	logic       aresetn;
	logic       prime_valid;
	key_word_t  prime_0, prime_1, prime_2, prime_3;
	logic       key_credit;
	logic       prime_credit;
	logic       key_valid;
	prime_idx_t key_index;
	key_word_t  key_d, key_c;

	prime_set_t  cur_p;              // set being sent
	prime_set_t  model_d, model_c;   // expected results for cur_p
	int          key_owed;           // output credits granted, not yet used
	int          tests_run, tests_failed, error_count;
	bit          composite [0:PRIME_TOP];
	int unsigned prime_tab [$];

	rsa_keygen_top rsa_keygen_top_inst (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.prime_valid  (prime_valid),
		.prime_0      (prime_0),
		.prime_1      (prime_1),
		.prime_2      (prime_2),
		.prime_3      (prime_3),
		.key_credit   (key_credit),
		.prime_credit (prime_credit),
		.key_valid    (key_valid),
		.key_index    (key_index),
		.key_d        (key_d),
		.key_c        (key_c)
	);

	rsa_keygen_checker u_checker (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.prime_valid  (prime_valid),
		.prime_credit (prime_credit),
		.key_credit   (key_credit),
		.key_valid    (key_valid),
		.key_index    (key_index),
		.key_d        (key_d),
		.key_c        (key_c),
		.model_d      (model_d),
		.model_c      (model_c),
		.tests_run    (tests_run),
		.tests_failed (tests_failed),
		.error_count  (error_count)
	);

	initial begin : clock_gen
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	// a^-1 mod m by the extended euclid recurrence on (r, t)
	function automatic longint mod_inverse(input longint a, input longint m);
		longint r0, r1, t0, t1, q, tmp;
		r0 = m;
		r1 = a % m;
		t0 = 0;
		t1 = 1;
		while (r1 != 0) begin
			q   = r0 / r1;
			tmp = r0 - q * r1;
			r0  = r1;
			r1  = tmp;
			tmp = t0 - q * t1;
			t0  = t1;
			t1  = tmp;
		end
		if (t0 < 0) t0 = t0 + m; // fold into 0..m-1
		return t0;
	endfunction

	task automatic compute_model();
		longint prod;
		for (int i = 0; i < `NUM_PRIMES; i++) begin
			model_d[i] = key_word_t'(mod_inverse(`PUB_EXP, longint'(cur_p[i]) - 1));
			prod = 1; // product of the other three primes, mod p_i
			for (int j = 0; j < `NUM_PRIMES; j++) begin
				if (j != i) prod = (prod * longint'(cur_p[j])) % longint'(cur_p[i]);
			end
			model_c[i] = key_word_t'(mod_inverse(prod, longint'(cur_p[i])));
		end
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic build_prime_table(); // sieve, odd primes only
		for (int n = 2; n * n <= PRIME_TOP; n++) begin
			if (!composite[n]) begin
				for (int m = n * n; m <= PRIME_TOP; m += n) composite[m] = 1'b1;
			end
		end
		for (int n = 3; n <= PRIME_TOP; n++) begin
			if (!composite[n]) prime_tab.push_back(n);
		end
	endtask

	task automatic pick_prime_set();
		int unsigned pick [`NUM_PRIMES];
		bit          clash;
		for (int k = 0; k < `NUM_PRIMES; k++) begin
			pick[k] = $urandom % prime_tab.size();
			for (int tries = 0; tries < `NUM_PRIMES; tries++) begin
				clash = 1'b0;
				for (int t = 0; t < k; t++) begin
					if (pick[t] == pick[k]) clash = 1'b1;
				end
				if (clash) pick[k] = (pick[k] + 1) % prime_tab.size(); // step past a repeat
			end
			cur_p[k] = key_word_t'(prime_tab[pick[k]]);
		end
	endtask

	task automatic wait_prime_credit(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < CREDIT_TIMEOUT) begin
			@(negedge aclk);
			seen = prime_credit;
			n++;
		end
	endtask

	task automatic send_prime_set(); // one-cycle valid spends the credit
		prime_0     = cur_p[0];
		prime_1     = cur_p[1];
		prime_2     = cur_p[2];
		prime_3     = cur_p[3];
		prime_valid = 1'b1;
		@(negedge aclk);
		prime_valid = 1'b0;
	endtask

	task automatic end_run(input bit timed_out);
		int bad;
		bad = tests_failed + error_count + (timed_out ? 1 : 0);
		if (tests_run != NUM_SETS + 1) begin
			$display("incomplete run: %0d of %0d tests finished", tests_run, NUM_SETS + 1);
			bad++;
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (bad == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// grants minus beats, as the consumer sees it
	always @(posedge aclk) begin
		if (!aresetn) begin
			key_owed <= 0;
		end else begin
			key_owed <= key_owed + int'(key_credit) - int'(key_valid);
		end
	end

	// ------------------------------
	// output credit traffic
	// ------------------------------
	initial begin : credit_gen
		int rate;
		int span;
		key_credit = 1'b0;
		rate       = 1;
		span       = 0;
		forever begin
			@(negedge aclk);
			if (span == 0) begin // new traffic phase
				rate = 1 + int'($urandom % 12);
				span = 16 + int'($urandom % 64);
			end
			span--;
			// rates of 10 and up model a stalled consumer
			key_credit = aresetn && (key_owed < `KEY_CREDITS) && (rate < 10) &&
			             (($urandom % rate) == 0);
		end
	end

	initial begin : main_seq
		bit timed_out;
		bit got;
		int gap;
		aresetn     = 1'b0;
		prime_valid = 1'b0;
		prime_0     = '0;
		prime_1     = '0;
		prime_2     = '0;
		prime_3     = '0;
		cur_p       = '0;
		model_d     = '0;
		model_c     = '0;
		timed_out   = 1'b0;
		void'($urandom(RAND_SEED));
		build_prime_table();
		repeat (RESET_CYCLES) @(negedge aclk);
		aresetn = 1'b1;
		for (int s = 0; s < NUM_SETS && !timed_out; s++) begin
			wait_prime_credit(got);
			if (!got) begin
				$display("timeout: no input credit for set %0d within %0d cycles",
					s, CREDIT_TIMEOUT);
				timed_out = 1'b1;
			end else begin
				pick_prime_set();
				compute_model();
				gap = int'($urandom % 3); // source may sit on its credit
				repeat (gap) @(negedge aclk);
				send_prime_set();
			end
		end
		if (!timed_out) begin
			wait_prime_credit(got); // last set fully sent once the credit returns
			if (!got) begin
				$display("timeout: last set did not finish within %0d cycles", CREDIT_TIMEOUT);
				timed_out = 1'b1;
			end
		end
		end_run(timed_out);
	end

endmodule

`default_nettype wire

//--- verilog/crt_combiner.sv
// crt coefficient build and credited result output
// four beats per set, index order, then set_done
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module crt_combiner import rsa_key_pkg::*, keygen_ctrl_pkg::*; (
	input  wire         aclk,
	input  wire         aresetn,
	input  wire         exp_done,
	input  wire         pairs_done,
	input  wire prime_set_t  exp_d,
	input  wire pair_table_t pair_inv,
	input  wire prime_set_t  prime_set,
	input  wire         key_credit, // consumer grants one credit
	output logic        key_valid,
	output prime_idx_t  key_index,
	output key_word_t   key_d,
	output key_word_t   key_c,
	output logic        set_done
);

	localparam int CNT_W = $clog2(`KEY_CREDITS + 1);

	seq_state_t       state;
	prime_idx_t       idx;         // row being built, then beat being sent
	logic             exp_seen, pairs_seen;
	logic [CNT_W-1:0] credits;
	prime_set_t       c_set;       // finished coefficients
	key_word_t        crt_val;
	logic             beat;

	// ------------------------------
	// c_i = prod_{j!=i} inv(p_j) mod p_i
	// ------------------------------
	always_comb begin : crt_row
		logic [2*`KEY_WIDTH-1:0] prod;
		key_word_t acc;
		acc  = key_word_t'(1);
		prod = '0;
		for (int j = 0; j < `NUM_PRIMES; j++) begin
			if (prime_idx_t'(j) != idx) begin
				prod = acc * pair_inv[idx][j];
				acc  = key_word_t'(prod % prime_set[idx]); // reduce each product
			end
		end
		crt_val = acc;
	end

	// output port
	assign beat      = (state == SEQ_WAIT) && (credits != '0);
	assign key_valid = beat;
	assign key_index = idx;
	assign key_d     = exp_d[idx];
	assign key_c     = c_set[idx];
	assign set_done  = (state == SEQ_HOLD); // cycle after beat 3

	// ------------------------------
	// credits, saturate at depth
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			credits <= '0;
		end else if (key_credit && !beat) begin
			if (credits != CNT_W'(`KEY_CREDITS)) credits <= credits + 1'b1;
		end else if (!key_credit && beat) begin
			credits <= credits - 1'b1;
		end
	end

	// both sides report once per set
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			exp_seen   <= 1'b0;
			pairs_seen <= 1'b0;
		end else if (state == SEQ_IDLE && exp_seen && pairs_seen) begin
			exp_seen   <= 1'b0;
			pairs_seen <= 1'b0;
		end else begin
			if (exp_done) exp_seen <= 1'b1;
			if (pairs_done) pairs_seen <= 1'b1;
		end
	end

	// ------------------------------
	// build then send
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= SEQ_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (exp_seen && pairs_seen) begin
						idx   <= '0;
						state <= SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: begin // one coefficient per cycle
					idx <= idx + 1'b1; // wraps back to 0 for the beats
					if (idx == prime_idx_t'(`NUM_PRIMES - 1)) state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin // stall here while no credit
					if (beat) begin
						idx <= idx + 1'b1;
						if (idx == prime_idx_t'(`NUM_PRIMES - 1)) state <= SEQ_HOLD;
					end
				end
				SEQ_HOLD: state <= SEQ_IDLE;
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == SEQ_ISSUE) begin
			c_set[idx] <= crt_val;
		end
	end

endmodule

`default_nettype wire

//--- verilog/exponent_unit.sv
// private exponent side
// d_i = e^-1 mod (p_i - 1), one engine run per prime
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module exponent_unit import rsa_key_pkg::*, keygen_ctrl_pkg::*; (
	input  wire        aclk,
	input  wire        aresetn,
	input  wire        set_start,
	input  wire prime_set_t prime_set,
	output prime_set_t exp_d,    // valid from exp_done on
	output logic       exp_done
);

	seq_state_t state;
	prime_idx_t idx;  // prime under work

	logic      eng_start, eng_done;
	key_word_t eng_num, eng_mod, eng_inv_num;

	assign eng_start = (state == SEQ_ISSUE);
	assign eng_num   = key_word_t'(`PUB_EXP);
	assign eng_mod   = prime_set[idx] - 1'b1; // phi contribution of p_i
	assign exp_done  = (state == SEQ_HOLD);

	// ------------------------------
	// job sequencer
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= SEQ_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (set_start) begin
						idx   <= '0;
						state <= SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: state <= SEQ_WAIT; // engine took the operands
				SEQ_WAIT: begin
					if (eng_done) begin
						if (idx == prime_idx_t'(`NUM_PRIMES - 1)) begin
							state <= SEQ_HOLD;
						end else begin
							idx   <= idx + 1'b1;
							state <= SEQ_ISSUE;
						end
					end
				end
				SEQ_HOLD: state <= SEQ_IDLE;
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// results land per prime
	always_ff @(posedge aclk) begin
		if (state == SEQ_WAIT && eng_done) begin
			exp_d[idx] <= eng_inv_num;
		end
	end

	ext_euclid_engine u_engine (
		.aclk    (aclk),
		.aresetn (aresetn),
		.start   (eng_start),
		.num     (eng_num),
		.modulus (eng_mod),
		.inv_num (eng_inv_num),
		.inv_mod (),            // e^-1 mod stays unused here
		.done    (eng_done)
	);

endmodule

`default_nettype wire

//--- verilog/ext_euclid_engine.sv
// iterative extended euclid engine
// returns both bezout inverses of two coprime operands
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module ext_euclid_engine import rsa_key_pkg::*, keygen_ctrl_pkg::*; (
	input  wire       aclk,
	input  wire       aresetn,
	input  wire       start,    // operands sampled with this
	input  wire key_word_t num,
	input  wire key_word_t modulus,
	output key_word_t inv_num,  // num^-1 mod modulus
	output key_word_t inv_mod,  // modulus^-1 mod num
	output logic      done      // one-cycle strobe
);

	euclid_state_t state;

	key_word_t r_prev, r_cur;                   // remainder pair
	logic signed [`KEY_WIDTH:0] t_prev, t_cur;  // coefficients of num
	logic signed [`KEY_WIDTH:0] s_prev, s_cur;  // coefficients of modulus
	key_word_t num_q, mod_q;                    // operands kept for the final fold

	key_word_t quo, rem;
	logic signed [`KEY_WIDTH:0] t_next, s_next;
	logic signed [`KEY_WIDTH:0] t_fix, s_fix;

	// ------------------------------
	// one quotient step
	// ------------------------------
	always_comb begin
		quo = '0;
		rem = r_prev;
		if (r_cur != '0) begin // guard divide by zero on the last step
			quo = r_prev / r_cur;
			rem = r_prev % r_cur;
		end
		// true values stay within +-modulus so wrap in width+1 bits is harmless
		t_next = t_prev - $signed({1'b0, quo}) * t_cur;
		s_next = s_prev - $signed({1'b0, quo}) * s_cur;
		// negative coefficient -> add the other operand once
		t_fix = t_prev[`KEY_WIDTH] ? t_prev + $signed({1'b0, mod_q}) : t_prev;
		s_fix = s_prev[`KEY_WIDTH] ? s_prev + $signed({1'b0, num_q}) : s_prev;
	end

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= EU_IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				EU_IDLE: if (start) state <= EU_STEP;
				EU_STEP: if (r_cur == '0) state <= EU_FINISH; // gcd sits in r_prev
				EU_FINISH: begin
					done  <= 1'b1;
					state <= EU_IDLE;
				end
				default: state <= EU_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge aclk) begin
		case (state)
			EU_IDLE: begin
				if (start) begin
					r_prev <= modulus;
					r_cur  <= num;
					t_prev <= '0;     // modulus = 0*num + 1*modulus
					t_cur  <= 'sd1;   // num     = 1*num + 0*modulus
					s_prev <= 'sd1;
					s_cur  <= '0;
					num_q  <= num;
					mod_q  <= modulus;
				end
			end
			EU_STEP: begin
				if (r_cur != '0) begin
					r_prev <= r_cur;
					r_cur  <= rem;
					t_prev <= t_cur;
					t_cur  <= t_next;
					s_prev <= s_cur;
					s_cur  <= s_next;
				end
			end
			EU_FINISH: begin
				inv_num <= t_fix[`KEY_WIDTH-1:0];
				inv_mod <= s_fix[`KEY_WIDTH-1:0]; // 0 when num is 1
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/keygen_ctrl_pkg.sv
// state encodings for the inverse engine and the sequencers
`default_nettype none

package keygen_ctrl_pkg;

	// extended euclid engine
	typedef enum logic [1:0] {
		EU_IDLE,   // waiting for start
		EU_STEP,   // one quotient step per cycle
		EU_FINISH  // fold coefficients into range
	} euclid_state_t;

	// job sequencers and combiner
	typedef enum logic [1:0] {
		SEQ_IDLE,  // waiting for work
		SEQ_ISSUE, // launch job / compute
		SEQ_WAIT,  // job in flight or beats pending
		SEQ_HOLD   // one-cycle done strobe
	} seq_state_t;

endpackage

`default_nettype wire

//--- verilog/pair_inverse_unit.sv
// pairwise inverse side
// six engine runs fill both halves of the inverse table
`timescale 1ns/10ps
`default_nettype none
`include "rsa_keygen_defs.svh"

module pair_inverse_unit import rsa_key_pkg::*, keygen_ctrl_pkg::*; (
	input  wire         aclk,
	input  wire         aresetn,
	input  wire         set_start,
	input  wire prime_set_t  prime_set,
	output pair_table_t pair_inv,   // [i][j] = p_j^-1 mod p_i
	output logic        pairs_done
);

	seq_state_t state;
	prime_idx_t idx_i, idx_j; // current pair, i < j

	logic      eng_start, eng_done;
	key_word_t eng_num, eng_mod, eng_inv_num, eng_inv_mod;
	logic      last_pair;

	assign eng_start  = (state == SEQ_ISSUE);
	assign eng_num    = prime_set[idx_j];
	assign eng_mod    = prime_set[idx_i];
	assign pairs_done = (state == SEQ_HOLD);
	assign last_pair  = (idx_i == prime_idx_t'(`NUM_PRIMES - 2)) &&
	                    (idx_j == prime_idx_t'(`NUM_PRIMES - 1));

	// ------------------------------
	// pair walk
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= SEQ_IDLE;
			idx_i <= '0;
			idx_j <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (set_start) begin
						idx_i <= '0;
						idx_j <= prime_idx_t'(1);
						state <= SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: state <= SEQ_WAIT;
				SEQ_WAIT: begin
					if (eng_done) begin
						if (last_pair) begin
							state <= SEQ_HOLD;
						end else if (idx_j == prime_idx_t'(`NUM_PRIMES - 1)) begin
							idx_i <= idx_i + 1'b1;      // next row
							idx_j <= idx_i + prime_idx_t'(2);
							state <= SEQ_ISSUE;
						end else begin
							idx_j <= idx_j + 1'b1;
							state <= SEQ_ISSUE;
						end
					end
				end
				SEQ_HOLD: state <= SEQ_IDLE;
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// one run gives both mirror entries
	always_ff @(posedge aclk) begin
		if (state == SEQ_IDLE && set_start) begin
			for (int k = 0; k < `NUM_PRIMES; k++) begin
				pair_inv[k][k] <= '0; // diagonal never read
			end
		end else if (state == SEQ_WAIT && eng_done) begin
			pair_inv[idx_i][idx_j] <= eng_inv_num; // p_j^-1 mod p_i
			pair_inv[idx_j][idx_i] <= eng_inv_mod; // p_i^-1 mod p_j
		end
	end

	ext_euclid_engine u_engine (
		.aclk    (aclk),
		.aresetn (aresetn),
		.start   (eng_start),
		.num     (eng_num),
		.modulus (eng_mod),
		.inv_num (eng_inv_num),
		.inv_mod (eng_inv_mod),
		.done    (eng_done)
	);

endmodule

`default_nettype wire

//--- verilog/prime_set_loader.sv
// input side: credit issue, prime set capture, set start
`timescale 1ns/10ps
`default_nettype none

module prime_set_loader import rsa_key_pkg::*; (
	input  wire        aclk,
	input  wire        aresetn,
	input  wire        prime_valid,  // source spends its credit
	input  wire key_word_t prime_0,
	input  wire key_word_t prime_1,
	input  wire key_word_t prime_2,
	input  wire key_word_t prime_3,
	input  wire        set_done,     // combiner finished the last beat
	output logic       prime_credit, // one credit per pulse
	output prime_set_t prime_set,
	output logic       set_start     // both sides kick off on this
);

	logic first_due; // first credit still owed after reset

	// ------------------------------
	// credit issue
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			first_due    <= 1'b1;
			prime_credit <= 1'b0;
		end else begin
			first_due    <= 1'b0;
			prime_credit <= first_due | set_done; // one set in flight at most
		end
	end

	// start strobe lines up with the captured set
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			set_start <= 1'b0;
		end else begin
			set_start <= prime_valid;
		end
	end

	// capture, held until the next set arrives
	always_ff @(posedge aclk) begin
		if (prime_valid) begin
			prime_set <= {prime_3, prime_2, prime_1, prime_0};
		end
	end

endmodule

`default_nettype wire

//--- verilog/rsa_key_pkg.sv
// arithmetic types for primes, key words and per-prime tables
`default_nettype none
`include "rsa_keygen_defs.svh"

package rsa_key_pkg;

	// one prime or one result word
	typedef logic [`KEY_WIDTH-1:0] key_word_t;

	// one word per prime, index = prime number
	typedef key_word_t [`NUM_PRIMES-1:0] prime_set_t;

	// [i][j] holds inv(prime j) mod prime i, diagonal unused
	typedef prime_set_t [`NUM_PRIMES-1:0] pair_table_t;

	// selects one of the four primes
	typedef logic [1:0] prime_idx_t;

endpackage

`default_nettype wire

//--- verilog/rsa_keygen_top.sv
// multi-prime rsa key generator top
// loader, two parallel inverse sides, combiner
`timescale 1ns/10ps
`default_nettype none

module rsa_keygen_top import rsa_key_pkg::*; (
	input  wire        aclk,
	input  wire        aresetn,
	input  wire        prime_valid,
	input  wire key_word_t prime_0,
	input  wire key_word_t prime_1,
	input  wire key_word_t prime_2,
	input  wire key_word_t prime_3,
	input  wire        key_credit,
	output logic       prime_credit,
	output logic       key_valid,
	output prime_idx_t key_index,
	output key_word_t  key_d,
	output key_word_t  key_c
);

	prime_set_t  prime_set;
	logic        set_start, set_done;
	prime_set_t  exp_d;
	logic        exp_done;
	pair_table_t pair_inv;
	logic        pairs_done;

	// ------------------------------
	// input side
	// ------------------------------
	prime_set_loader u_loader (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.prime_valid  (prime_valid),
		.prime_0      (prime_0),
		.prime_1      (prime_1),
		.prime_2      (prime_2),
		.prime_3      (prime_3),
		.set_done     (set_done),
		.prime_credit (prime_credit),
		.prime_set    (prime_set),
		.set_start    (set_start)
	);

	// both sides run on the same set
	exponent_unit u_exp (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.set_start (set_start),
		.prime_set (prime_set),
		.exp_d     (exp_d),
		.exp_done  (exp_done)
	);

	pair_inverse_unit u_pairs (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.set_start  (set_start),
		.prime_set  (prime_set),
		.pair_inv   (pair_inv),
		.pairs_done (pairs_done)
	);

	// ------------------------------
	// output side
	// ------------------------------
	crt_combiner u_comb (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.exp_done   (exp_done),
		.pairs_done (pairs_done),
		.exp_d      (exp_d),
		.pair_inv   (pair_inv),
		.prime_set  (prime_set),
		.key_credit (key_credit),
		.key_valid  (key_valid),
		.key_index  (key_index),
		.key_d      (key_d),
		.key_c      (key_c),
		.set_done   (set_done)
	);

endmodule

`default_nettype wire
